//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int WORD_W = 32;
	localparam int IMM_W = 16;
	localparam int SHAMT_W = 5;
	localparam int OP_W = 6;

	// Instruction word layout
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 26;
	localparam int SHAMT_MSB = 10;
	localparam int SHAMT_LSB = 6;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

	localparam int DIV_STEPS = 32; // One quotient bit per step
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [IMM_W-1:0] imm16_t;
	typedef logic [SHAMT_W-1:0] shamt_t;

	typedef enum logic [OP_W-1:0] {
		OP_ADD = 6'd8,
		OP_ADDI = 6'd9,
		OP_SUB = 6'd10,
		OP_LUI = 6'd11,
		OP_DIV = 6'd12,
		OP_MULT = 6'd13,
		OP_DIVI = 6'd14,
		OP_MULTI = 6'd15,
		OP_SLL = 6'd16,
		OP_SRA = 6'd17,
		OP_SRL = 6'd18,
		OP_AND = 6'd20,
		OP_ANDI = 6'd21,
		OP_OR = 6'd22,
		OP_ORI = 6'd23,
		OP_XOR = 6'd24,
		OP_XORI = 6'd25,
		OP_NOR = 6'd26
	} op_t;

	typedef enum logic [1:0] {
		SHIFT_NONE,
		SHIFT_LEFT,
		SHIFT_RIGHT_ARITH,
		SHIFT_RIGHT_LOGIC
	} shift_dir_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

	typedef struct packed {
		op_t op;
		imm16_t imm;
		word_t imm_x; // Sign-extended imm
		shamt_t shamt;
		word_t rs;
		word_t rt;
	} exec_op_t;

endpackage

`default_nettype wire

//--- verilog/barrel_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module barrel_shifter (
	input exec_pkg::word_t value,
	input exec_pkg::shamt_t shamt,
	input exec_pkg::shift_dir_t dir,
	output exec_pkg::word_t shifted
);

	import exec_pkg::*;

	// Stage i moves the word by 2**i
	genvar i;
	generate
		for (i = 0; i < SHAMT_W; i++) begin : g_stage
			word_t stage_in;
			word_t stage_out;
			if (i == 0) begin : g_first
				assign stage_in = value;
			end else begin : g_chain
				assign stage_in = g_stage[i-1].stage_out;
			end
			always_comb begin
				stage_out = stage_in;
				if (shamt[i]) begin
					case (dir)
						SHIFT_LEFT: begin
							stage_out = {stage_in[WORD_W-1-2**i:0], {(2**i){1'b0}}};
						end
						SHIFT_RIGHT_ARITH: begin
							stage_out = {{(2**i){value[WORD_W-1]}}, stage_in[WORD_W-1:2**i]};
						end
						SHIFT_RIGHT_LOGIC: begin
							stage_out = {{(2**i){1'b0}}, stage_in[WORD_W-1:2**i]};
						end
						default: ;
					endcase
				end
			end
		end
	endgenerate

	assign shifted = g_stage[SHAMT_W-1].stage_out;

endmodule

`default_nettype wire

//--- verilog/divider.sv
`timescale 1ns/1ns
`default_nettype none

module divider (
	input logic clk,
	input logic reset,
	input logic enabled,
	input exec_pkg::word_t dividend,
	input exec_pkg::word_t divisor,
	output exec_pkg::word_t quotient,
	output logic completed
);

	import exec_pkg::*;

	div_state_t state;
	word_t rem;
	word_t quo;
	word_t dvsr;
	logic [DIV_CNT_W-1:0] step;
	logic [WORD_W:0] partial;
	logic [WORD_W:0] trial;

	// Shift in the next dividend bit and try the subtraction
	always_comb begin
		partial = {rem, quo[WORD_W-1]};
		trial = partial - {1'b0, dvsr};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DIV_IDLE;
		end else if (!enabled) begin
			state <= DIV_IDLE; // Dropping enabled aborts
		end else begin
			case (state)
				DIV_IDLE: state <= DIV_RUN;
				DIV_RUN: begin
					if (step == DIV_CNT_W'(DIV_STEPS - 1)) begin
						state <= DIV_DONE;
					end
				end
				default: state <= DIV_DONE; // Hold until enabled falls
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == DIV_IDLE) begin
			rem <= '0;
			quo <= dividend;
			dvsr <= divisor;
			step <= '0;
		end else if (state == DIV_RUN) begin
			if (trial[WORD_W]) begin
				rem <= partial[WORD_W-1:0]; // Restore
				quo <= {quo[WORD_W-2:0], 1'b0};
			end else begin
				rem <= trial[WORD_W-1:0];
				quo <= {quo[WORD_W-2:0], 1'b1}; // Zero divisor always lands here
			end
			step <= step + 1'b1;
		end
	end

	assign quotient = quo;
	assign completed = (state == DIV_DONE);

endmodule

`default_nettype wire

//--- verilog/inst_field_decode.sv
`timescale 1ns/1ns
`default_nettype none

module inst_field_decode (
	input logic clk,
	input logic reset,
	input logic issue,
	input exec_pkg::word_t inst,
	input exec_pkg::word_t rs_val,
	input exec_pkg::word_t rt_val,
	output exec_pkg::exec_op_t dec,
	output logic start
);

	import exec_pkg::*;

	exec_op_t dec_next;

	always_comb begin
		dec_next.op = op_t'(inst[OP_MSB:OP_LSB]); // Unlisted codes decode as no-op
		dec_next.imm = inst[IMM_MSB:IMM_LSB];
		dec_next.imm_x = {{(WORD_W - IMM_W){inst[IMM_MSB]}}, inst[IMM_MSB:IMM_LSB]};
		dec_next.shamt = inst[SHAMT_MSB:SHAMT_LSB];
		dec_next.rs = rs_val;
		dec_next.rt = rt_val;
	end

	// Operands stay frozen between issues
	always_ff @(posedge clk) begin
		if (issue) begin
			dec <= dec_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= issue; // One cycle behind issue
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu_exec_element.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec_element (
	input logic clk,
	input logic reset,
	input logic start,
	input exec_pkg::exec_op_t dec,
	output exec_pkg::word_t result,
	output logic completed
);

	import exec_pkg::*;

	shift_dir_t shift_dir;
	word_t shifted;
	word_t op_value;
	logic op_single;
	logic is_mul;
	word_t mul_b;
	word_t prod;
	logic busy;
	word_t div_divisor;
	word_t div_quotient;
	logic div_enabled;
	logic div_completed;

	barrel_shifter u_shifter (
		.value(dec.rs),
		.shamt(dec.shamt),
		.dir(shift_dir),
		.shifted(shifted)
	);

	divider u_divider (
		.clk(clk),
		.reset(reset),
		.enabled(div_enabled),
		.dividend(dec.rs),
		.divisor(div_divisor),
		.quotient(div_quotient),
		.completed(div_completed)
	);

	assign div_divisor = (dec.op == OP_DIVI) ? dec.imm_x : dec.rt;
	assign is_mul = (dec.op == OP_MULT) || (dec.op == OP_MULTI);
	assign mul_b = (dec.op == OP_MULTI) ? dec.imm_x : dec.rt;

	always_comb begin
		case (dec.op)
			OP_SLL: shift_dir = SHIFT_LEFT;
			OP_SRA: shift_dir = SHIFT_RIGHT_ARITH;
			OP_SRL: shift_dir = SHIFT_RIGHT_LOGIC;
			default: shift_dir = SHIFT_NONE;
		endcase
	end

	// Single-cycle results
	always_comb begin
		op_value = result; // Unknown ops keep the old value
		op_single = 1'b1;
		case (dec.op)
			OP_ADD: op_value = dec.rs + dec.rt;
			OP_ADDI: op_value = dec.rs + dec.imm_x;
			OP_SUB: op_value = dec.rs - dec.rt;
			OP_LUI: op_value = {dec.imm, {(WORD_W - IMM_W){1'b0}}};
			OP_SLL, OP_SRA, OP_SRL: op_value = shifted;
			OP_AND: op_value = dec.rs & dec.rt;
			OP_ANDI: op_value = {{(WORD_W - IMM_W){1'b0}}, dec.rs[IMM_W-1:0] & dec.imm};
			OP_OR: op_value = dec.rs | dec.rt;
			OP_ORI: op_value = {dec.rs[WORD_W-1:IMM_W], dec.rs[IMM_W-1:0] | dec.imm};
			OP_XOR: op_value = dec.rs ^ dec.rt;
			OP_XORI: op_value = {dec.rs[WORD_W-1:IMM_W], dec.rs[IMM_W-1:0] ^ dec.imm};
			OP_NOR: op_value = ~(dec.rs | dec.rt);
			OP_DIV, OP_DIVI, OP_MULT, OP_MULTI: op_single = 1'b0;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			completed <= 1'b0;
			busy <= 1'b0;
			div_enabled <= 1'b0;
		end else if (start || busy) begin
			if (start) begin
				busy <= 1'b1;
				completed <= 1'b0;
				div_enabled <= 1'b0; // Also aborts a divide in flight
			end
			if (op_single) begin
				result <= op_value;
				busy <= 1'b0;
				completed <= 1'b1;
			end else if (is_mul) begin
				if (start) begin
					prod <= word_t'($signed(dec.rs) * $signed(mul_b)); // Low half only
				end else begin
					result <= prod;
					busy <= 1'b0;
					completed <= 1'b1;
				end
			end else begin
				if (!div_enabled) begin
					div_enabled <= 1'b1;
				end else if (!start && div_completed) begin
					result <= div_quotient;
					div_enabled <= 1'b0;
					busy <= 1'b0;
					completed <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
	input logic clk,
	input logic reset,
	input logic issue,
	input exec_pkg::word_t inst,
	input exec_pkg::word_t rs_val,
	input exec_pkg::word_t rt_val,
	input exec_pkg::word_t pc, // No operation reads it
	output exec_pkg::word_t result,
	output logic completed
);

	import exec_pkg::*;

	exec_op_t dec;
	logic start;

	inst_field_decode u_decode (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.inst(inst),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.dec(dec),
		.start(start)
	);

	alu_exec_element u_alu (
		.clk(clk),
		.reset(reset),
		.start(start),
		.dec(dec),
		.result(result),
		.completed(completed)
	);

endmodule

`default_nettype wire

//--- sim/exec_tests.svh
task automatic test_arith_logic();
	word_t a;
	word_t b;
	imm16_t imm;
	int i;
	for (i = 0; i < 4; i++) begin
		a = word_t'($random(seed));
		b = word_t'($random(seed));
		run_op("add", OP_ADD, 16'h0, a, b, a + b, 1);
		run_op("sub", OP_SUB, 16'h0, a, b, a - b, 1);
		run_op("and", OP_AND, 16'h0, a, b, a & b, 1);
		run_op("or", OP_OR, 16'h0, a, b, a | b, 1);
		run_op("xor", OP_XOR, 16'h0, a, b, a ^ b, 1);
		run_op("nor", OP_NOR, 16'h0, a, b, ~(a | b), 1);
	end
	a = word_t'($random(seed));
	imm = 16'h8000 | imm16_t'($random(seed)); // Negative immediate
	run_op("addi", OP_ADDI, imm, a, 32'h0, a + sign_extend(imm), 1);
	imm = imm16_t'($random(seed));
	run_op("lui", OP_LUI, imm, a, a, {imm, 16'h0000}, 1);
endtask

task automatic test_imm_logic();
	word_t a;
	imm16_t imm;
	int i;
	for (i = 0; i < 4; i++) begin
		a = word_t'($random(seed));
		a = (i == 0) ? (a | 32'hffff_0000) : a;
		imm = imm16_t'($random(seed));
		run_op("andi", OP_ANDI, imm, a, 32'h0, a & {16'h0000, imm}, 1);
		run_op("ori", OP_ORI, imm, a, 32'h0, a | {16'h0000, imm}, 1);
		run_op("xori", OP_XORI, imm, a, 32'h0, a ^ {16'h0000, imm}, 1);
	end
endtask

// Shift amount sits in bits 10..6 of the word
task automatic run_shift_set(input word_t a, input shamt_t sh);
	imm16_t imm;
	imm = {5'b0, sh, 6'b0};
	run_op("sll", OP_SLL, imm, a, 32'h0, a << sh, 1);
	run_op("srl", OP_SRL, imm, a, 32'h0, a >> sh, 1);
	run_op("sra", OP_SRA, imm, a, 32'h0, word_t'($signed(a) >>> sh), 1);
endtask

task automatic test_shifts();
	shamt_t amounts [4];
	int i;
	amounts = '{5'd0, 5'd1, 5'd16, 5'd31};
	for (i = 0; i < 4; i++) begin
		run_shift_set(word_t'($random(seed)) & 32'h7fff_ffff, amounts[i]);
		run_shift_set(word_t'($random(seed)) | 32'h8000_0000, amounts[i]); // Negative rs
	end
	for (i = 0; i < 4; i++) begin
		run_shift_set(word_t'($random(seed)), shamt_t'($random(seed)));
	end
endtask

task automatic test_multiply();
	word_t a;
	word_t b;
	imm16_t imm;
	int i;
	// Bit 0 picks the sign of rs, bit 1 the sign of the other operand
	for (i = 0; i < 4; i++) begin
		a = word_t'($random(seed));
		b = word_t'($random(seed));
		imm = imm16_t'($random(seed));
		a = i[0] ? (a | 32'h8000_0000) : (a & 32'h7fff_ffff);
		b = i[1] ? (b | 32'h8000_0000) : (b & 32'h7fff_ffff);
		imm = i[1] ? (imm | 16'h8000) : (imm & 16'h7fff);
		run_op("mult", OP_MULT, 16'h0, a, b, mul_low(a, b), 2);
		run_op("multi", OP_MULTI, imm, a, 32'h0, mul_low(a, sign_extend(imm)), 2);
	end
endtask

task automatic test_divide();
	word_t a;
	word_t b;
	imm16_t imm;
	int i;
	for (i = 0; i < 4; i++) begin
		a = word_t'($random(seed));
		b = word_t'($random(seed)) >> (8 * i); // Smaller divisors, larger quotients
		imm = imm16_t'($random(seed));
		imm = i[0] ? imm : (imm & 16'h00ff);
		run_op("div", OP_DIV, 16'h0, a, b, udiv(a, b), 0);
		run_op("divi", OP_DIVI, imm, a, 32'h0, udiv(a, sign_extend(imm)), 0);
	end
	a = word_t'($random(seed));
	run_op("div by zero", OP_DIV, 16'h0, a, 32'h0, 32'hffff_ffff, 0);
	run_op("divi by zero", OP_DIVI, 16'h0, a, 32'h0, 32'hffff_ffff, 0);
endtask

task automatic test_unknown_op();
	word_t a;
	word_t b;
	word_t prev;
	int i;
	a = word_t'($random(seed));
	b = word_t'($random(seed));
	prev = a + b;
	run_op("add before unknown", OP_ADD, 16'h0, a, b, prev, 1);
	run_op("unknown op 0", 6'd0, 16'h1234, ~a, b, prev, 1);
	run_op("unknown op 19", 6'd19, 16'hbeef, a, a, prev, 1);
	run_op("unknown op 63", 6'd63, 16'hffff, b, b, prev, 1);
	for (i = 0; i < 6; i++) begin
		@(negedge clk);
		assert (completed === 1'b1) else begin
			value_errors++;
			$display("ERROR at %0t: completed expected 1 actual %b while idle", $time, completed);
		end
	end
	// Latency 2 means completed was low one edge after issue
	run_op("mult after unknown", OP_MULT, 16'h0, a, b, mul_low(a, b), 2);
endtask

//--- sim/exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_tb;

	import exec_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int DONE_TIMEOUT = 64; // Cycles allowed per operation
	localparam int OP_COUNT = 100; // Issued operations, rounded up
	localparam int WATCHDOG_CYCLES = OP_COUNT * DONE_TIMEOUT + 200;

	logic clk;
	logic reset;
	logic issue;
	word_t inst;
	word_t rs_val;
	word_t rt_val;
	word_t pc;
	word_t result;
	logic completed;

	int seed;
	int value_errors;
	int latency_errors;
	int timeout_errors;

	exec_stage dut (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.inst(inst),
		.rs_val(rs_val),
		.rt_val(rt_val),
		.pc(pc),
		.result(result),
		.completed(completed)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t sign_extend(input imm16_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t mul_low(input word_t a, input word_t b);
		longint pa;
		longint pb;
		pa = longint'($signed(a));
		pb = longint'($signed(b));
		return word_t'(pa * pb);
	endfunction

	function automatic word_t udiv(input word_t a, input word_t b);
		if (b == 32'h0) begin
			return 32'hffff_ffff;
		end
		return a / b;
	endfunction

	// Returns the edge count after the issue edge, or -1 on timeout
	task automatic issue_op(input logic [5:0] op_code, input imm16_t imm, input word_t rs,
			input word_t rt, output int latency);
		int cycles;
		@(posedge clk);
		issue <= 1'b1;
		inst <= {op_code, 10'd0, imm};
		rs_val <= rs;
		rt_val <= rt;
		pc <= pc + 32'd4;
		@(posedge clk); // Issue sampled here
		issue <= 1'b0;
		cycles = 0;
		latency = -1;
		while (latency < 0 && cycles < DONE_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			if (completed) begin
				latency = cycles;
			end
		end
	endtask

	task automatic run_op(input string name, input logic [5:0] op_code, input imm16_t imm,
			input word_t rs, input word_t rt, input word_t expected, input int exp_latency);
		int latency;
		issue_op(op_code, imm, rs, rt, latency);
		assert (latency >= 0) else begin
			timeout_errors++;
			$display("Operation %s did not complete within %0d cycles", name, DONE_TIMEOUT);
		end
		if (latency >= 0) begin
			assert (result === expected) else begin
				value_errors++;
				$display("ERROR at %0t: result expected %h actual %h (%s)",
					$time, expected, result, name);
			end
			if (exp_latency > 0) begin
				assert (latency == exp_latency) else begin
					latency_errors++;
					$display("ERROR at %0t: completed latency expected %0d actual %0d (%s)",
						$time, exp_latency, latency, name);
				end
			end
		end
	endtask

	`include "exec_tests.svh"

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	initial begin
		clk = 1'b0;
		seed = 32'hb2fb48d1;
		value_errors = 0;
		latency_errors = 0;
		timeout_errors = 0;
		reset = 1'b1;
		issue = 1'b0;
		inst = '0;
		rs_val = '0;
		rt_val = '0;
		pc = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (result === 32'h0) else begin
			value_errors++;
			$display("ERROR at %0t: result expected 00000000 actual %h after reset",
				$time, result);
		end
		assert (completed === 1'b0) else begin
			value_errors++;
			$display("ERROR at %0t: completed expected 0 actual %b after reset",
				$time, completed);
		end
		test_arith_logic();
		test_imm_logic();
		test_shifts();
		test_multiply();
		test_divide();
		test_unknown_op();
		$display("Errors: value %0d, latency %0d, timeout %0d",
			value_errors, latency_errors, timeout_errors);
		if (value_errors + latency_errors + timeout_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
verilog/exec_pkg.sv
verilog/barrel_shifter.sv
verilog/divider.sv
verilog/inst_field_decode.sv
verilog/alu_exec_element.sv
verilog/exec_stage.sv
sim/exec_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module exec_tb -o exec_sim
./obj_dir/exec_sim | tee sim.log
if grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED, see sim.log"
	exit 1
fi
echo "Simulation PASSED"
